// File: hdl/dma_cfg_pkg.sv
// DMA read path configuration: bus widths, AXI constants and default sizes
`default_nettype none

package dma_cfg_pkg;

   // ************************************************************************
   // Bus widths
   // ************************************************************************
   localparam int ADDR_WIDTH     = 32; // External and TCDM byte address
   localparam int DATA_WIDTH     = 64; // One AXI beat / one TCDM word
   localparam int LEN_WIDTH      = 15; // Command length in bytes
   localparam int TID_WIDTH      = 4;  // Transaction ID, also the AXI ID
   localparam int AXI_LEN_WIDTH  = 8;  // AXI4 burst length field

   // Bytes to beats
   localparam int BEAT_BYTES_LOG = 3;
   localparam logic [2:0] AXI_SIZE_BEAT = 3'd3; // 8 bytes per beat

   // ************************************************************************
   // Default sizes, overridden from the top level
   // ************************************************************************
   localparam int NB_OUTSTANDING_DEF = 4; // Bursts in flight
   localparam int CMD_DEPTH_DEF      = 4; // Command queue entries
   localparam int BEAT_DEPTH_DEF     = 8; // Response beat queue entries

endpackage

`default_nettype wire

// File: hdl/dma_types_pkg.sv
// DMA read path payload types for commands, issued bursts and response beats
`default_nettype none

package dma_types_pkg;

   import dma_cfg_pkg::*;

   // One queued command as it arrives on the req/gnt port
   typedef struct packed {
      logic [ADDR_WIDTH-1:0] ext_add;  // Source byte address in external memory
      logic [ADDR_WIDTH-1:0] tcdm_add; // Destination byte address in TCDM
      logic [LEN_WIDTH-1:0]  len;      // Length in bytes
      logic                  bst;      // INCR burst when set, FIXED otherwise
   } dma_cmd_t;

   // Issued burst, held from the AR handshake until its last beat is written
   typedef struct packed {
      logic [ADDR_WIDTH-1:0] tcdm_add; // Base address of the write sequence
      logic [TID_WIDTH-1:0]  tid;      // ID reported on done
   } dma_trans_t;

   // One accepted R beat
   // The AXI ID does not travel with the data
   typedef struct packed {
      logic [DATA_WIDTH-1:0] data;
      logic                  last;     // Closes the burst
   } dma_beat_t;

endpackage

`default_nettype wire

// File: hdl/dma_tid_if.sv
// Link between the read control and the transaction ID pool
`default_nettype none

interface dma_tid_if #(
   parameter int TID_WIDTH = 4
) ();

   logic                 valid;   // At least one ID is free
   logic [TID_WIDTH-1:0] tid;     // Lowest free ID
   logic                 alloc;   // Take tid this cycle
   logic                 rel;     // Give rel_tid back to the pool
   logic [TID_WIDTH-1:0] rel_tid;

   modport pool (output valid, tid, input alloc, rel, rel_tid);
   modport ctrl (input valid, tid, output alloc, rel, rel_tid);

endinterface

`default_nettype wire

// File: hdl/dma_fifo.sv
// Synchronous circular queue with a type-parameterized payload and visible head
`default_nettype none

module dma_fifo #(
   parameter type T     = logic,
   parameter int  DEPTH = 4
) (
   input  logic clk_i,
   input  logic rst_ni,
   input  logic push_i,
   input  T     wdata_i,
   output logic full_o,
   input  logic pop_i,
   output T     rdata_o,
   output logic empty_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T                 mem_q [DEPTH];     // Storage, no reset needed
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] cnt_q;             // Occupancy
   logic             do_push;
   logic             do_pop;

   // Wraps at DEPTH, also for sizes that are not a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full_o  = (cnt_q == CNT_W'(DEPTH));
   assign empty_o = (cnt_q == '0);        // Flags come from registered count
   assign do_push = push_i && !full_o;    // Drop a push into a full queue
   assign do_pop  = pop_i && !empty_o;
   assign rdata_o = mem_q[rd_ptr_q];      // Head is always on the output

   always_ff @(posedge clk_i)
   begin
      if (do_push)
         mem_q[wr_ptr_q] <= wdata_i;
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end
      else
      begin
         if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
         if (do_push && !do_pop)      cnt_q <= cnt_q + 1'b1;
         else if (do_pop && !do_push) cnt_q <= cnt_q - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hdl/dma_tid_pool.sv
// Transaction ID pool: free-bit vector with lowest-free allocation and release
`default_nettype none

module dma_tid_pool
   import dma_cfg_pkg::*;
#(
   parameter int NB_OUTSTANDING = NB_OUTSTANDING_DEF
) (
   input  logic      clk_i,
   input  logic      rst_ni,
   dma_tid_if.pool   tid_p
);

   // One bit per ID, so at most NB_OUTSTANDING bursts can be open
   logic [NB_OUTSTANDING-1:0] free_q;

   // Priority search, the lowest free ID wins
   always_comb
   begin
      tid_p.valid = |free_q;
      tid_p.tid   = '0;
      for (int i = NB_OUTSTANDING - 1; i >= 0; i--)
      begin
         if (free_q[i])
            tid_p.tid = TID_WIDTH'(i);
      end
   end

   // Alloc and release never hit the same ID in one cycle
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         free_q <= '1;                    // All IDs free
      else
      begin
         for (int i = 0; i < NB_OUTSTANDING; i++)
         begin
            if (tid_p.alloc && tid_p.tid == TID_WIDTH'(i))
               free_q[i] <= 1'b0;         // Taken by an AR handshake
            else if (tid_p.rel && tid_p.rel_tid == TID_WIDTH'(i))
               free_q[i] <= 1'b1;         // Burst closed on its last beat
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/dma_rx_ctrl.sv
// AXI4 read control: AR issue with beat count and R beat acceptance
`default_nettype none

module dma_rx_ctrl
   import dma_cfg_pkg::*, dma_types_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_ni,

   // Command queue head
   input  dma_cmd_t                 cmd_i,
   input  logic                     cmd_empty_i,
   output logic                     cmd_pop_o,

   // Transaction queue tail
   output dma_trans_t               trans_o,
   input  logic                     trans_full_i,
   output logic                     trans_push_o,

   // ID pool
   dma_tid_if.ctrl                  tid_c,

   // AXI4 read address channel
   output logic                     ar_valid_o,
   output logic [ADDR_WIDTH-1:0]    ar_addr_o,
   output logic [AXI_LEN_WIDTH-1:0] ar_len_o,
   output logic [2:0]               ar_size_o,
   output logic [1:0]               ar_burst_o,
   output logic [TID_WIDTH-1:0]     ar_id_o,
   input  logic                     ar_ready_i,

   // AXI4 read data channel
   input  logic                     r_valid_i,
   input  logic [DATA_WIDTH-1:0]    r_data_i,
   input  logic                     r_last_i,
   input  logic [TID_WIDTH-1:0]     r_id_i,
   output logic                     r_ready_o,

   // Beat queue tail
   output dma_beat_t                beat_o,
   input  logic                     beat_full_i,
   output logic                     beat_push_o
);

   logic [LEN_WIDTH-1:0]      beats_nb;  // Aligned burst length
   logic [BEAT_BYTES_LOG:0]   low_sum;   // Carry bit marks a crossed word
   logic                      rel_q;
   logic [TID_WIDTH-1:0]      rel_tid_q;

   // ************************************************************************
   // Beat count
   // ************************************************************************
   assign low_sum  = {1'b0, cmd_i.ext_add[BEAT_BYTES_LOG-1:0]}
                   + {1'b0, cmd_i.len[BEAT_BYTES_LOG-1:0]};
   assign beats_nb = (cmd_i.len >> BEAT_BYTES_LOG)
                   + LEN_WIDTH'(low_sum[BEAT_BYTES_LOG]); // One more if sum >= 8

   // ************************************************************************
   // Request side
   // ************************************************************************
   // Valid only when slave, pool and both queues all agree
   assign ar_valid_o   = !cmd_empty_i && ar_ready_i && tid_c.valid && !trans_full_i;
   assign cmd_pop_o    = ar_valid_o;     // Handshake completes in this cycle
   assign tid_c.alloc  = ar_valid_o;
   assign trans_push_o = ar_valid_o;
   assign trans_o      = '{tcdm_add: cmd_i.tcdm_add, tid: tid_c.tid};

   assign ar_addr_o  = cmd_i.ext_add;
   assign ar_len_o   = beats_nb[AXI_LEN_WIDTH-1:0];
   assign ar_size_o  = AXI_SIZE_BEAT;
   assign ar_burst_o = {1'b0, cmd_i.bst};  // FIXED or INCR
   assign ar_id_o    = tid_c.tid;

   // ************************************************************************
   // Response side
   // ************************************************************************
   assign r_ready_o   = !beat_full_i;
   assign beat_push_o = r_valid_i && r_ready_o;
   assign beat_o      = '{data: r_data_i, last: r_last_i};

   // Release registered, the ID comes back one cycle after the last beat
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         rel_q <= 1'b0;
      else
         rel_q <= beat_push_o && r_last_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (beat_push_o && r_last_i)
         rel_tid_q <= r_id_i;             // Slave answers in issue order
   end

   assign tid_c.rel     = rel_q;
   assign tid_c.rel_tid = rel_tid_q;

endmodule

`default_nettype wire

// File: hdl/dma_tcdm_wr.sv
// TCDM writer: walks each burst over consecutive words and flags its last beat
`default_nettype none

module dma_tcdm_wr
   import dma_cfg_pkg::*, dma_types_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  dma_beat_t             beat_i,
   input  logic                  beat_empty_i,
   output logic                  beat_pop_o,
   input  dma_trans_t            trans_i,
   input  logic                  trans_empty_i,
   output logic                  trans_pop_o,
   output logic                  tcdm_req_o,
   output logic [ADDR_WIDTH-1:0] tcdm_add_o,
   output logic [DATA_WIDTH-1:0] tcdm_wdata_o,
   input  logic                  tcdm_gnt_i,
   output logic                  done_o,
   output logic [TID_WIDTH-1:0]  done_tid_o
);

   localparam int OFF_W = ADDR_WIDTH - BEAT_BYTES_LOG;

   typedef enum logic {IDLE, RUN} state_e;

   state_e                state_q, state_d;
   logic [OFF_W-1:0]      off_q;         // Word offset inside the burst
   logic [ADDR_WIDTH-1:0] base_q;        // Base latched on the first beat
   logic                  wr_fire;

   // A beat always has its transaction queued ahead of it
   assign tcdm_req_o   = !beat_empty_i && !trans_empty_i;
   assign wr_fire      = tcdm_req_o && tcdm_gnt_i;
   assign tcdm_wdata_o = beat_i.data;    // Held by the queue head while stalled
   assign beat_pop_o   = wr_fire;
   assign trans_pop_o  = wr_fire && beat_i.last;
   assign done_o       = trans_pop_o;    // Same cycle as the last grant
   assign done_tid_o   = trans_i.tid;

   // First word goes straight to the head address
   always_comb
   begin
      if (state_q == IDLE)
         tcdm_add_o = trans_i.tcdm_add;
      else
         tcdm_add_o = base_q + {off_q, {BEAT_BYTES_LOG{1'b0}}};
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:    if (wr_fire && !beat_i.last) state_d = RUN;  // Burst longer than one
         RUN:     if (wr_fire && beat_i.last)  state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q <= IDLE;
         off_q   <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (wr_fire)
            off_q <= beat_i.last ? '0 : off_q + 1'b1;  // Eight bytes per beat
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (state_q == IDLE && wr_fire)
         base_q <= trans_i.tcdm_add;
   end

endmodule

`default_nettype wire

// File: hdl/dma_rx_top.sv
// DMA read path top: command queue, AXI read control, ID pool, beat queue, TCDM writer
`default_nettype none

module dma_rx_top
   import dma_cfg_pkg::*, dma_types_pkg::*;
#(
   parameter int NB_OUTSTANDING = NB_OUTSTANDING_DEF,
   parameter int CMD_DEPTH      = CMD_DEPTH_DEF,
   parameter int BEAT_DEPTH     = BEAT_DEPTH_DEF
) (
   input  logic                     clk_i,
   input  logic                     rst_ni,
   // Command port
   input  logic                     cmd_req_i,
   input  logic [ADDR_WIDTH-1:0]    cmd_ext_add_i,
   input  logic [ADDR_WIDTH-1:0]    cmd_tcdm_add_i,
   input  logic [LEN_WIDTH-1:0]     cmd_len_i,
   input  logic                     cmd_bst_i,
   output logic                     cmd_gnt_o,
   // AXI4 AR
   output logic                     ar_valid_o,
   output logic [ADDR_WIDTH-1:0]    ar_addr_o,
   output logic [AXI_LEN_WIDTH-1:0] ar_len_o,
   output logic [2:0]               ar_size_o,
   output logic [1:0]               ar_burst_o,
   output logic [TID_WIDTH-1:0]     ar_id_o,
   input  logic                     ar_ready_i,
   // AXI4 R
   input  logic                     r_valid_i,
   input  logic [DATA_WIDTH-1:0]    r_data_i,
   input  logic                     r_last_i,
   input  logic [TID_WIDTH-1:0]     r_id_i,
   output logic                     r_ready_o,
   // TCDM
   output logic                     tcdm_req_o,
   output logic [ADDR_WIDTH-1:0]    tcdm_add_o,
   output logic [DATA_WIDTH-1:0]    tcdm_wdata_o,
   input  logic                     tcdm_gnt_i,
   // Completion
   output logic                     done_o,
   output logic [TID_WIDTH-1:0]     done_tid_o
);

   dma_cmd_t   cmd_in, cmd_head;
   dma_trans_t trans_in, trans_head;
   dma_beat_t  beat_in, beat_head;
   logic       cmd_push, cmd_full, cmd_empty, cmd_pop;
   logic       trans_push, trans_full, trans_empty, trans_pop;
   logic       beat_push, beat_full, beat_empty, beat_pop;

   dma_tid_if #(.TID_WIDTH(TID_WIDTH)) tid_link ();

   // Command taken on req and gnt both high
   assign cmd_gnt_o = !cmd_full;
   assign cmd_push  = cmd_req_i && cmd_gnt_o;
   assign cmd_in    = '{ext_add: cmd_ext_add_i, tcdm_add: cmd_tcdm_add_i,
                        len: cmd_len_i, bst: cmd_bst_i};

   dma_fifo #(.T(dma_cmd_t), .DEPTH(CMD_DEPTH)) i_cmd_fifo (
      .clk_i, .rst_ni, .push_i(cmd_push), .wdata_i(cmd_in), .full_o(cmd_full),
      .pop_i(cmd_pop), .rdata_o(cmd_head), .empty_o(cmd_empty));

   // One entry per open burst
   dma_fifo #(.T(dma_trans_t), .DEPTH(NB_OUTSTANDING)) i_trans_fifo (
      .clk_i, .rst_ni, .push_i(trans_push), .wdata_i(trans_in), .full_o(trans_full),
      .pop_i(trans_pop), .rdata_o(trans_head), .empty_o(trans_empty));

   dma_fifo #(.T(dma_beat_t), .DEPTH(BEAT_DEPTH)) i_beat_fifo (
      .clk_i, .rst_ni, .push_i(beat_push), .wdata_i(beat_in), .full_o(beat_full),
      .pop_i(beat_pop), .rdata_o(beat_head), .empty_o(beat_empty));

   dma_tid_pool #(.NB_OUTSTANDING(NB_OUTSTANDING)) i_tid_pool (
      .clk_i, .rst_ni, .tid_p(tid_link.pool));

   dma_rx_ctrl i_rx_ctrl (
      .clk_i, .rst_ni,
      .cmd_i(cmd_head), .cmd_empty_i(cmd_empty), .cmd_pop_o(cmd_pop),
      .trans_o(trans_in), .trans_full_i(trans_full), .trans_push_o(trans_push),
      .tid_c(tid_link.ctrl),
      .ar_valid_o, .ar_addr_o, .ar_len_o, .ar_size_o, .ar_burst_o, .ar_id_o, .ar_ready_i,
      .r_valid_i, .r_data_i, .r_last_i, .r_id_i, .r_ready_o,
      .beat_o(beat_in), .beat_full_i(beat_full), .beat_push_o(beat_push));

   dma_tcdm_wr i_tcdm_wr (
      .clk_i, .rst_ni,
      .beat_i(beat_head), .beat_empty_i(beat_empty), .beat_pop_o(beat_pop),
      .trans_i(trans_head), .trans_empty_i(trans_empty), .trans_pop_o(trans_pop),
      .tcdm_req_o, .tcdm_add_o, .tcdm_wdata_o, .tcdm_gnt_i,
      .done_o, .done_tid_o);

endmodule

`default_nettype wire

// File: tests/dma_rx_asserts.sv
// Protocol checks on the AR channel, the TCDM port and the idle state right after reset
`default_nettype none

module dma_rx_asserts
   import dma_cfg_pkg::*;
(
   input logic                     clk_i,
   input logic                     rst_ni,
   input logic                     cmd_empty_i,
   input logic                     ar_valid_i,
   input logic [ADDR_WIDTH-1:0]    ar_addr_i,
   input logic [AXI_LEN_WIDTH-1:0] ar_len_i,
   input logic [2:0]               ar_size_i,
   input logic [1:0]               ar_burst_i,
   input logic                     tcdm_req_i,
   input logic [ADDR_WIDTH-1:0]    tcdm_add_i,
   input logic [DATA_WIDTH-1:0]    tcdm_wdata_i,
   input logic                     tcdm_gnt_i,
   input logic                     done_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // AR fields come from the command head and stay frozen until it is issued
   ar_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !cmd_empty_i && !ar_valid_i |=> $stable(ar_addr_i) && $stable(ar_len_i)
         && $stable(ar_size_i) && $stable(ar_burst_i))
      else $error("AR request changed before its handshake");

   tcdm_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      tcdm_req_i && !tcdm_gnt_i |=> tcdm_req_i && $stable(tcdm_add_i)
         && $stable(tcdm_wdata_i))
      else $error("TCDM request changed before its grant");

   reset_idle_a: assert property (@(posedge clk_i)
      $rose(rst_ni) |-> !ar_valid_i && !tcdm_req_i && !done_i)
      else $error("Outputs not idle in the first cycle after reset");

endmodule

bind dma_rx_top dma_rx_asserts i_asserts (
   .clk_i, .rst_ni, .cmd_empty_i(cmd_empty),
   .ar_valid_i(ar_valid_o), .ar_addr_i(ar_addr_o), .ar_len_i(ar_len_o),
   .ar_size_i(ar_size_o), .ar_burst_i(ar_burst_o),
   .tcdm_req_i(tcdm_req_o), .tcdm_add_i(tcdm_add_o), .tcdm_wdata_i(tcdm_wdata_o),
   .tcdm_gnt_i, .done_i(done_o));

`default_nettype wire

// File: tests/tb_dma_rx.sv
// Testbench for the DMA read path with file stimulus, AXI slave model, scoreboard and timeout
`default_nettype none

module tb_dma_rx
   import dma_cfg_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NB_OUT = 4;                  // Bursts in flight and also the pool size

   logic                     clk_i, rst_ni;
   logic                     cmd_req_i, cmd_bst_i, cmd_gnt_o;
   logic [ADDR_WIDTH-1:0]    cmd_ext_add_i, cmd_tcdm_add_i;
   logic [LEN_WIDTH-1:0]     cmd_len_i;
   logic                     ar_valid_o, ar_ready_i;
   logic [ADDR_WIDTH-1:0]    ar_addr_o, tcdm_add_o;
   logic [AXI_LEN_WIDTH-1:0] ar_len_o;
   logic [2:0]               ar_size_o;
   logic [1:0]               ar_burst_o;
   logic [TID_WIDTH-1:0]     ar_id_o, r_id_i, done_tid_o;
   logic                     r_valid_i, r_last_i, r_ready_o;
   logic [DATA_WIDTH-1:0]    r_data_i, tcdm_wdata_o;
   logic                     tcdm_req_o, tcdm_gnt_i, done_o;

   // Stimulus table with one entry per command
   logic [31:0]              st_ext[$], st_tcdm[$];
   int                       st_len[$], st_bst[$], st_beats[$];
   int                       st_ar_stall[$], st_gnt_stall[$]; // Percent
   logic [TID_WIDTH-1:0]     ar_id_rec[$];      // ID seen on each AR in command order
   logic [DATA_WIDTH-1:0]    exp_data[$];       // Words sent by the slave and not yet written
   int                       sl_beats[$];       // Slave model burst queue
   logic [TID_WIDTH-1:0]     sl_id[$];
   logic [(1<<TID_WIDTH)-1:0] open_flag;        // IDs between AR and last R beat
   logic [31:0]              rng;
   logic                     r_hold;            // R beat offered but not yet taken
   logic [31:0]              f_ext, f_tcdm;
   int                       f_len, f_bst, f_beats, f_ars, f_gns;
   int                       n_cmds, total_beats, limit, cyc, idx, fd;
   int                       cmd_idx, ar_cnt, done_cnt, wr_k, rb, open_cnt;
   string                    line;

   dma_rx_top #(
      .NB_OUTSTANDING(NB_OUT),
      .CMD_DEPTH(4),
      .BEAT_DEPTH(8)
   ) DUT (.*);

   always #2 clk_i = ~clk_i;                    // 4 ns period

   // ************************************************************************
   // Helpers
   // ************************************************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act)
      begin
         $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
         $display("Regression failed");
         $fatal(1);
      end
   endtask

   // Lines starting with # are column notes
   task automatic read_stimulus();
      fd = $fopen("tests/dma_rx_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open tests/dma_rx_stimulus.txt for reading");
         $display("Regression failed");
         $fatal(1);
      end
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() > 1 && line.getc(0) != "#")
         begin
            if ($sscanf(line, "%h %h %d %d %d %d %d", f_ext, f_tcdm, f_len, f_bst,
                        f_beats, f_ars, f_gns) == 7)
            begin
               st_ext.push_back(f_ext);
               st_tcdm.push_back(f_tcdm);
               st_len.push_back(f_len);
               st_bst.push_back(f_bst);
               st_beats.push_back(f_beats);
               st_ar_stall.push_back(f_ars);
               st_gnt_stall.push_back(f_gns);
               total_beats += f_beats;
            end
         end
      end
      $fclose(fd);
   endtask

   // ************************************************************************
   // Falling edge drive
   // ************************************************************************
   task automatic drive_inputs();
      cmd_req_i = (cmd_idx < n_cmds);             // Back to back until gnt drops
      if (cmd_idx < n_cmds)
      begin
         cmd_ext_add_i  = st_ext[cmd_idx];
         cmd_tcdm_add_i = st_tcdm[cmd_idx];
         cmd_len_i      = LEN_WIDTH'(st_len[cmd_idx]);
         cmd_bst_i      = (st_bst[cmd_idx] != 0);
      end
      idx = (ar_cnt < n_cmds) ? ar_cnt : 0;       // Stall of the next AR
      rng = xorshift32(rng);
      ar_ready_i = (int'(rng % 32'd100) >= st_ar_stall[idx]);
      idx = (done_cnt < n_cmds) ? done_cnt : 0;   // Stall of the burst being written
      rng = xorshift32(rng);
      tcdm_gnt_i = (int'(rng % 32'd100) >= st_gnt_stall[idx]);
      if (!r_hold)
      begin
         rng = xorshift32(rng);
         r_valid_i = (sl_beats.size() > 0) && (rng[1:0] != 2'b00); // Gap one in four
         if (r_valid_i)
         begin
            rng = xorshift32(rng);
            r_data_i[63:32] = rng;
            rng = xorshift32(rng);
            r_data_i[31:0] = rng;
            r_last_i = (rb == sl_beats[0] - 1);
            r_id_i   = sl_id[0];
         end
      end
   endtask

   // ************************************************************************
   // Sampling just before the rising edge
   // ************************************************************************
   task automatic sample_outputs();
      if (cmd_req_i && cmd_gnt_o)
         cmd_idx++;
      if (r_valid_i && r_ready_o)
      begin
         exp_data.push_back(r_data_i);
         if (r_last_i)
         begin
            open_flag[r_id_i] = 1'b0;             // Burst no longer open
            open_cnt--;
            void'(sl_beats.pop_front());
            void'(sl_id.pop_front());
            rb = 0;
         end
         else
            rb++;
      end
      r_hold = r_valid_i && !r_ready_o;           // AXI keeps an offered beat
      if (ar_valid_o && ar_ready_i)
      begin
         check("ar in command order", 64'd1, 64'(ar_cnt < n_cmds));
         check("ar_addr", 64'(st_ext[ar_cnt]), 64'(ar_addr_o));
         check("ar_len", 64'(st_beats[ar_cnt]), 64'(ar_len_o) + 64'd1);
         check("ar_size", 64'd3, 64'(ar_size_o));
         check("ar_burst", 64'(st_bst[ar_cnt] & 1), 64'(ar_burst_o));
         check("ar_id free", 64'd0, 64'(open_flag[ar_id_o]));
         open_flag[ar_id_o] = 1'b1;
         open_cnt++;
         check("outstanding bursts", 64'd1, 64'(open_cnt <= NB_OUT));
         ar_id_rec.push_back(ar_id_o);
         sl_beats.push_back(st_beats[ar_cnt]);
         sl_id.push_back(ar_id_o);
         ar_cnt++;
      end
      if (tcdm_req_o && tcdm_gnt_i)
      begin
         check("tcdm write for a known command", 64'd1, 64'(done_cnt < n_cmds));
         check("tcdm beat received", 64'd1, 64'(exp_data.size() > 0));
         check("tcdm_add", 64'(st_tcdm[done_cnt] + 8 * wr_k), 64'(tcdm_add_o));
         check("tcdm_wdata", exp_data.pop_front(), tcdm_wdata_o);
         check("done_o", 64'(wr_k == st_beats[done_cnt] - 1), 64'(done_o));
         if (done_o)
         begin
            check("done_tid", 64'(ar_id_rec[done_cnt]), 64'(done_tid_o));
            done_cnt++;
            wr_k = 0;
         end
         else
            wr_k++;
      end
      else
         check("done_o without grant", 64'd0, 64'(done_o));
   endtask

   initial
   begin
      clk_i          = 1'b0;
      rst_ni         = 1'b0;
      cmd_req_i      = 1'b0;
      cmd_ext_add_i  = '0;
      cmd_tcdm_add_i = '0;
      cmd_len_i      = '0;
      cmd_bst_i      = 1'b0;
      ar_ready_i     = 1'b0;
      r_valid_i      = 1'b0;
      r_data_i       = '0;
      r_last_i       = 1'b0;
      r_id_i         = '0;
      tcdm_gnt_i     = 1'b0;
      rng            = 32'd43;                    // Seed
      r_hold         = 1'b0;
      open_flag      = '0;
      total_beats    = 0;
      cyc            = 0;
      cmd_idx        = 0;
      ar_cnt         = 0;
      done_cnt       = 0;
      wr_k           = 0;
      rb             = 0;
      open_cnt       = 0;
      read_stimulus();
      n_cmds = st_ext.size();
      limit  = 200 + 20 * total_beats;
      check("stimulus commands", 64'd1, 64'(n_cmds > 0));
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      #1;
      // Idle outputs right after reset
      check("reset ar_valid", 64'd0, 64'(ar_valid_o));
      check("reset r_ready", 64'd1, 64'(r_ready_o));   // Beat queue empty so not full
      check("reset tcdm_req", 64'd0, 64'(tcdm_req_o));
      check("reset done", 64'd0, 64'(done_o));
      check("reset cmd_gnt", 64'd1, 64'(cmd_gnt_o));
      while (done_cnt < n_cmds)
      begin
         @(negedge clk_i);
         drive_inputs();
         #1;
         sample_outputs();
         cyc++;
         if (cyc >= limit)
         begin
            $display("Timeout after %0d cycles with %0d of %0d commands done",
                     cyc, done_cnt, n_cmds);
            $display("Regression failed");
            $fatal(1);
         end
      end
      // No further writes or completions once every command is closed
      repeat (8)
      begin
         @(negedge clk_i);
         drive_inputs();
         #1;
         check("extra tcdm_req", 64'd0, 64'(tcdm_req_o));
         check("extra done pulse", 64'd0, 64'(done_o));
      end
      check("beats left over", 64'd0, 64'(exp_data.size()));
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/dma_rx_stimulus.txt
# ext_add(hex) tcdm_add(hex) len(dec bytes) bst beats(=ar_len+1)
# ar_ready stall % and tcdm_gnt stall % (dec)
80000000 00001000 64 1 9 0 0
80000104 00001100 20 1 4 20 10
80000203 00001200 3 0 1 30 30
80000307 00001300 1 1 2 10 50
80000400 00001400 0 1 1 0 0
80000505 00001500 100 1 14 25 25
80000606 00001600 7 0 2 50 0
80000700 00001700 255 1 32 10 40
80000801 00001900 15 1 3 40 60
80000902 00001a00 40 1 6 0 70
80000a06 00001b00 9 1 2 60 20

// File: sim.f
hdl/dma_cfg_pkg.sv
hdl/dma_types_pkg.sv
hdl/dma_tid_if.sv
hdl/dma_fifo.sv
hdl/dma_tid_pool.sv
hdl/dma_rx_ctrl.sv
hdl/dma_tcdm_wr.sv
hdl/dma_rx_top.sv
tests/dma_rx_asserts.sv
tests/tb_dma_rx.sv

// File: Makefile
# Verilator build and run of the DMA read path testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_rx
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
